/* project.f */
hw/fifo_pkg.sv
hw/fifo_ptr_unit.sv
hw/fifo_mem.sv
hw/fifo_ctrl_fsm.sv
hw/fifo_top.sv
tests/fifo_props.sv
tests/tb_fifo.sv

/* Makefile */
SIM := obj_dir/Vtb_fifo

.PHONY: all run clean

all: run

$(SIM): project.f $(wildcard hw/*.sv) $(wildcard tests/*.sv)
	verilator --binary --assert --top-module tb_fifo -f project.f -o Vtb_fifo

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_fifo.sv */
`default_nettype none

module tb_fifo;

   import fifo_pkg::*;

   localparam int depth = 4;
   localparam int num_stim = 25;

   typedef struct packed {
      logic [2:0] test;
      logic       push;
      logic       pop;
      logic [7:0] data;
   } stim_t;

   logic         clk;
   logic         reset;
   logic         push;
   logic         pop;
   logic [7:0]   wr_data;
   logic [7:0]   rd_data;
   fifo_status_t status;

   logic [7:0]   model [$];  // reference contents with the head at index 0
   int           test_errors;
   int           tests_passed;
   int           tests_failed;
   integer       seed;

   // test id, push, pop, data
   stim_t stim [num_stim] = '{
      '{3'd2, 1'b1, 1'b0, 8'ha1},  // fill to full
      '{3'd2, 1'b1, 1'b0, 8'ha2},
      '{3'd2, 1'b1, 1'b0, 8'ha3},
      '{3'd2, 1'b1, 1'b0, 8'ha4},
      '{3'd3, 1'b1, 1'b0, 8'hee},  // overflow byte that must never come out
      '{3'd3, 1'b0, 1'b0, 8'h00},
      '{3'd4, 1'b0, 1'b1, 8'h00},  // drain then underflow
      '{3'd4, 1'b0, 1'b1, 8'h00},
      '{3'd4, 1'b0, 1'b1, 8'h00},
      '{3'd4, 1'b0, 1'b1, 8'h00},
      '{3'd4, 1'b0, 1'b1, 8'h00},
      '{3'd4, 1'b0, 1'b0, 8'h00},
      '{3'd5, 1'b1, 1'b0, 8'h11},  // partial occupancy
      '{3'd5, 1'b1, 1'b0, 8'h22},
      '{3'd5, 1'b1, 1'b1, 8'h33},
      '{3'd5, 1'b1, 1'b0, 8'h44},
      '{3'd5, 1'b1, 1'b0, 8'h55},
      '{3'd5, 1'b1, 1'b1, 8'h66},  // full stays full
      '{3'd5, 1'b0, 1'b1, 8'h00},
      '{3'd5, 1'b0, 1'b1, 8'h00},
      '{3'd5, 1'b0, 1'b1, 8'h00},
      '{3'd5, 1'b0, 1'b1, 8'h00},
      '{3'd5, 1'b1, 1'b1, 8'h77},  // empty takes only the push
      '{3'd5, 1'b0, 1'b1, 8'h00},
      '{3'd5, 1'b0, 1'b0, 8'h00}
   };

   fifo_top #(
      .data_width (8),
      .addr_width (2)
   ) u_dut (
      .clk     (clk),
      .reset   (reset),
      .push    (push),
      .pop     (pop),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .status  (status)
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // checks and reporting
   //////////////////////////////////////////////////

   task automatic check_bit(input string name, input logic exp, input logic act);
      assert (act === exp) else begin
         $display("Fail at %0t: %s expected %0b, got %0b", $time, name, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         $display("Fail at %0t: %s expected %02h, got %02h", $time, name, exp, act);
         test_errors++;
      end
   endtask

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "reset state";
         3'd2:    return "fill to full";
         3'd3:    return "overflow";
         3'd4:    return "drain and underflow";
         3'd5:    return "simultaneous push and pop";
         default: return "random mix";
      endcase
   endfunction

   task automatic finish_test(input logic [2:0] id);
      if (test_errors == 0) begin
         $display("test %0d %s: ok", id, test_name(id));
         tests_passed++;
      end else begin
         $display("test %0d %s: %0d errors", id, test_name(id), test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   //////////////////////////////////////////////////
   // one cycle against the queue model
   //////////////////////////////////////////////////

   // called on a falling edge and returns on the next one
   task automatic apply_cycle(input logic do_push, input logic do_pop, input logic [7:0] data);
      logic pop_ok;
      logic push_ok;
      logic exp_err;
      push    = do_push;
      pop     = do_pop;
      wr_data = data;
      @(posedge clk);
      pop_ok  = do_pop && (model.size() != 0);
      push_ok = do_push && ((model.size() != depth) || pop_ok);  // a pop frees the slot
      exp_err = (do_push && !push_ok) || (do_pop && !pop_ok);
      if (pop_ok) begin
         void'(model.pop_front());
      end
      if (push_ok) begin
         model.push_back(data);
      end
      @(negedge clk);
      push = 1'b0;
      pop  = 1'b0;
      check_bit("status.empty", model.size() == 0, status.empty);
      check_bit("status.full", model.size() == depth, status.full);
      check_bit("status.err", exp_err, status.err);
      if (model.size() != 0) begin
         check_byte("rd_data", model[0], rd_data);
      end
   endtask

   task automatic drain_to_empty(input int limit);
      int n;
      n = 0;
      while (status.empty !== 1'b1 && n < limit) begin
         apply_cycle(1'b0, 1'b1, 8'h00);
         n++;
      end
      if (status.empty !== 1'b1) begin
         $display("timeout: FIFO did not drain within %0d pops", limit);
         test_errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      logic [2:0]  cur;
      logic [31:0] r;
      clk          = 1'b0;
      reset        = 1'b1;
      push         = 1'b0;
      pop          = 1'b0;
      wr_data      = 8'h00;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      seed         = 32'hdaf6;

      // strobes while reset is held must leave pointers and flags alone
      @(negedge clk);
      push    = 1'b1;
      pop     = 1'b1;
      wr_data = 8'h5a;
      repeat (7) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      push  = 1'b0;
      pop   = 1'b0;

      check_bit("status.empty", 1'b1, status.empty);
      check_bit("status.full", 1'b0, status.full);
      check_bit("status.err", 1'b0, status.err);
      apply_cycle(1'b0, 1'b0, 8'h00);
      finish_test(3'd1);

      cur = stim[0].test;
      for (int i = 0; i < num_stim; i++) begin
         if (stim[i].test != cur) begin
            finish_test(cur);
            cur = stim[i].test;
         end
         apply_cycle(stim[i].push, stim[i].pop, stim[i].data);
      end
      finish_test(cur);

      // even odds on both strobes keep the pointers wrapping
      for (int i = 0; i < 60; i++) begin
         r = $random(seed);
         apply_cycle(r[0], r[1], r[15:8]);
      end
      drain_to_empty(2 * depth);
      finish_test(3'd6);

      $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/fifo_props.sv */
`default_nettype none

module fifo_props (
   input logic                    clk,
   input logic                    reset,
   input logic                    push,
   input logic                    pop,
   input fifo_pkg::fifo_state_t   state,
   input fifo_pkg::ptr_ctrl_t     ctrl,
   input fifo_pkg::fifo_status_t  status
);

   import fifo_pkg::*;

   //////////////////////////////////////////////////
   // flag and strobe properties
   //////////////////////////////////////////////////

   flags_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(status.empty && status.full))
      else $error("empty and full are high in the same cycle");

   push_leaves_empty: assert property (@(posedge clk) disable iff (reset)
      (state == st_empty && push) |=> !status.empty)
      else $error("a push into the empty FIFO left the empty flag high");

   // with no strobe in the pulse cycle nothing can keep err high
   err_single_pulse: assert property (@(posedge clk) disable iff (reset)
      (status.err && !push && !pop) |=> !status.err)
      else $error("err stayed high for a second cycle after one strobe");

   quiet_in_reset: assert property (@(posedge clk)
      reset |-> (!ctrl.rd_en && !ctrl.wr_en))
      else $error("a pointer enable was high during reset");

endmodule

bind fifo_ctrl_fsm fifo_props u_props (
   .clk    (clk),
   .reset  (reset),
   .push   (push),
   .pop    (pop),
   .state  (state),
   .ctrl   (ctrl),
   .status (status)
);

`default_nettype wire

/* hw/fifo_top.sv */
`default_nettype none

module fifo_top #(
   parameter int data_width = 8,
   parameter int addr_width = 2
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    push,
   input  logic                    pop,
   input  logic [data_width-1:0]   wr_data,
   output logic [data_width-1:0]   rd_data,
   output fifo_pkg::fifo_status_t  status
);

   import fifo_pkg::*;

   ptr_ctrl_t             ctrl;
   ptr_cmp_t              cmp;
   logic [addr_width-1:0] rd_ptr;
   logic [addr_width-1:0] wr_ptr;

   //////////////////////////////////////////////////
   // occupancy controller
   //////////////////////////////////////////////////

   fifo_ctrl_fsm u_ctrl (
      .clk    (clk),
      .reset  (reset),
      .push   (push),
      .pop    (pop),
      .cmp    (cmp),
      .ctrl   (ctrl),
      .status (status)
   );

   //////////////////////////////////////////////////
   // pointers
   //////////////////////////////////////////////////

   fifo_ptr_unit #(
      .addr_width (addr_width)
   ) u_ptr (
      .clk    (clk),
      .reset  (reset),
      .ctrl   (ctrl),
      .rd_ptr (rd_ptr),
      .wr_ptr (wr_ptr),
      .cmp    (cmp)
   );

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   // an accepted push writes where the write pointer points before it advances
   fifo_mem #(
      .data_width (data_width),
      .addr_width (addr_width)
   ) u_mem (
      .clk     (clk),
      .wr_en   (ctrl.wr_en),
      .wr_addr (wr_ptr),
      .wr_data (wr_data),
      .rd_addr (rd_ptr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

/* hw/fifo_ctrl_fsm.sv */
`default_nettype none

module fifo_ctrl_fsm (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    push,
   input  logic                    pop,
   input  fifo_pkg::ptr_cmp_t      cmp,
   output fifo_pkg::ptr_ctrl_t     ctrl,
   output fifo_pkg::fifo_status_t  status
);

   import fifo_pkg::*;

   fifo_state_t state;
   fifo_state_t state_next;
   logic        push_ok;
   logic        pop_ok;
   logic        recover;
   logic        err_next;

   //////////////////////////////////////////////////
   // acceptance
   //////////////////////////////////////////////////

   // acceptance depends on the current state alone and a pop frees the slot a push needs
   assign pop_ok  = pop && (state != st_empty);
   assign push_ok = push && ((state != st_full) || pop_ok);

   //////////////////////////////////////////////////
   // next state and pointer control
   //////////////////////////////////////////////////

   always_comb begin
      ctrl       = '0;
      state_next = state;
      err_next   = (push && !push_ok) || (pop && !pop_ok);

      // pointers that disagree with the state mean the registers are corrupt
      case (state)
         st_empty, st_full:             recover = !cmp.ptr_equal;
         st_going_full, st_going_empty: recover = cmp.ptr_equal;
         default:                       recover = 1'b1;
      endcase

      if (recover) begin
         ctrl.rd_clr = 1'b1;  // start over from an empty buffer
         ctrl.wr_clr = 1'b1;
         err_next    = 1'b1;
         state_next  = st_empty;
      end else begin
         ctrl.rd_en = pop_ok && !reset;  // no pointer moves while reset is held
         ctrl.wr_en = push_ok && !reset;
         if (push_ok && !pop_ok) begin
            // from empty the write pointer can never sit one behind the read one
            if ((state != st_empty) && cmp.wr_next_hits_rd) begin
               state_next = st_full;
            end else begin
               state_next = st_going_full;
            end
         end else if (pop_ok && !push_ok) begin
            if (cmp.rd_next_hits_wr) begin
               state_next = st_empty;
            end else begin
               state_next = st_going_empty;
            end
         end
         // push and pop together leave the occupancy where it was
      end
   end

   //////////////////////////////////////////////////
   // state and status registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= st_empty;
         status.empty  <= 1'b1;
         status.full   <= 1'b0;
         status.err    <= 1'b0;
      end else begin
         state         <= state_next;
         status.empty  <= (state_next == st_empty);
         status.full   <= (state_next == st_full);
         status.err    <= err_next;  // high for the cycle after the bad strobe
      end
   end

endmodule

`default_nettype wire

/* hw/fifo_mem.sv */
`default_nettype none

module fifo_mem #(
   parameter int data_width = 8,
   parameter int addr_width = 2
) (
   input  logic                    clk,
   input  logic                    wr_en,
   input  logic [addr_width-1:0]   wr_addr,
   input  logic [data_width-1:0]   wr_data,
   input  logic [addr_width-1:0]   rd_addr,
   output logic [data_width-1:0]   rd_data
);

   localparam int depth = 2 ** addr_width;

   logic [data_width-1:0] mem [depth];

   //////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   //////////////////////////////////////////////////
   // read port
   //////////////////////////////////////////////////

   // word at the read pointer shows without a clock, so the head falls through
   assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

/* hw/fifo_ptr_unit.sv */
`default_nettype none

module fifo_ptr_unit #(
   parameter int addr_width = 2
) (
   input  logic                    clk,
   input  logic                    reset,
   input  fifo_pkg::ptr_ctrl_t     ctrl,
   output logic [addr_width-1:0]   rd_ptr,
   output logic [addr_width-1:0]   wr_ptr,
   output fifo_pkg::ptr_cmp_t      cmp
);

   logic [addr_width-1:0] rd_ptr_inc;
   logic [addr_width-1:0] wr_ptr_inc;

   // both pointers wrap on their own at the top of the address range
   assign rd_ptr_inc = rd_ptr + addr_width'(1);
   assign wr_ptr_inc = wr_ptr + addr_width'(1);

   //////////////////////////////////////////////////
   // pointer registers
   //////////////////////////////////////////////////

   // a clear wins over an advance in the same cycle
   always_ff @(posedge clk) begin
      if (reset || ctrl.rd_clr) begin
         rd_ptr <= '0;
      end else if (ctrl.rd_en) begin
         rd_ptr <= rd_ptr_inc;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || ctrl.wr_clr) begin
         wr_ptr <= '0;
      end else if (ctrl.wr_en) begin
         wr_ptr <= wr_ptr_inc;
      end
   end

   //////////////////////////////////////////////////
   // pointer relations
   //////////////////////////////////////////////////

   // equal pointers alone cannot tell full from empty, the controller state
   // resolves that, and the next-position compares say when a single push or
   // pop is about to close the gap
   always_comb begin
      cmp.ptr_equal       = (rd_ptr == wr_ptr);
      cmp.wr_next_hits_rd = (wr_ptr_inc == rd_ptr);  // one push from full
      cmp.rd_next_hits_wr = (rd_ptr_inc == wr_ptr);  // one pop from empty
   end

endmodule

`default_nettype wire

/* hw/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

   //////////////////////////////////////////////////
   // occupancy controller state
   //////////////////////////////////////////////////

   // the going states remember the last net change, push or pop
   typedef enum logic [1:0] {
      st_empty       = 2'b00,
      st_going_full  = 2'b01,
      st_going_empty = 2'b10,
      st_full        = 2'b11
   } fifo_state_t;

   //////////////////////////////////////////////////
   // status and pointer handshakes
   //////////////////////////////////////////////////

   typedef struct packed {
      logic empty;
      logic full;
      logic err;  // one cycle pulse on overflow, underflow or recovery
   } fifo_status_t;

   typedef struct packed {
      logic rd_en;
      logic wr_en;
      logic rd_clr;
      logic wr_clr;
   } ptr_ctrl_t;

   typedef struct packed {
      logic ptr_equal;
      logic wr_next_hits_rd;
      logic rd_next_hits_wr;
   } ptr_cmp_t;

endpackage

`default_nettype wire
